// ==== m62_pkg.sv ====
package m62_pkg;

	// download and memory geometry
	localparam int byte_aw = 20;
	localparam int word_aw = 17;   // 128k words or 256 KiB

	// cpu side address widths
	localparam int cpu_aw = 17;
	localparam int snd_aw = 16;

	// rom map in download byte addresses
	localparam logic [byte_aw-1:0] cpu_base = 20'h00000;
	localparam logic [byte_aw-1:0] snd_base = 20'h20000;
	localparam logic [byte_aw-1:0] rom_end  = 20'h30000;   // gfx and proms start here

	// game stays in reset this many clk_sys cycles after loading
	localparam int reset_hold = 64;

	typedef struct packed {
		logic [7:0] hi;   // odd byte
		logic [7:0] lo;   // even byte
	} rom_bytes_t;

	// one memory word seen whole or as its two byte lanes
	typedef union packed {
		logic [15:0] word;
		rom_bytes_t  b;
	} rom_word_t;

endpackage

// ==== rom_dl_ctrl.sv ====
`timescale 1ns/1ps

module rom_dl_ctrl (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        dl_active,
	input  logic                        dl_wr,
	input  logic [m62_pkg::byte_aw-1:0] dl_addr,
	input  logic [7:0]                  dl_data,
	input  logic                        wr_gnt,
	output logic                        wr_req,
	output logic [m62_pkg::word_aw-1:0] wr_addr,
	output logic [15:0]                 wr_data,
	output logic [1:0]                  wr_be,
	output logic                        rom_loaded
);

	logic dl_wr_d;
	logic dl_active_d;
	logic dl_take;

	// rising edge of the strobe inside the download and below rom_end
	assign dl_take = dl_active & dl_wr & ~dl_wr_d & (dl_addr < m62_pkg::rom_end);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dl_wr_d     <= 1'b0;
			dl_active_d <= 1'b0;
			wr_req      <= 1'b0;
			rom_loaded  <= 1'b0;
		end else begin
			dl_wr_d     <= dl_wr;
			dl_active_d <= dl_active;

			// strobes are spaced widely so one pending slot is enough
			if (dl_take)
				wr_req <= 1'b1;
			else if (wr_gnt)
				wr_req <= 1'b0;

			if (dl_active_d && !dl_active)
				rom_loaded <= 1'b1;   // sticky until rst_n
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dl_take) begin
			wr_addr <= dl_addr[m62_pkg::word_aw:1];
			wr_data <= {dl_data, dl_data};   // same byte on both lanes
			wr_be   <= {dl_addr[0], ~dl_addr[0]};
		end
	end

endmodule

// ==== rom_arbiter.sv ====
`timescale 1ns/1ps

module rom_arbiter (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        wr_req,
	input  logic [m62_pkg::word_aw-1:0] wr_addr,
	input  logic [15:0]                 wr_data,
	input  logic [1:0]                  wr_be,
	input  logic                        cpu_req,
	input  logic [m62_pkg::word_aw-1:0] cpu_addr,
	input  logic                        snd_req,
	input  logic [m62_pkg::word_aw-1:0] snd_addr,
	input  logic [15:0]                 mem_rdata,
	output logic                        wr_gnt,
	output logic                        cpu_gnt,
	output logic                        snd_gnt,
	output logic                        mem_en,
	output logic                        mem_we,
	output logic [1:0]                  mem_be,
	output logic [m62_pkg::word_aw-1:0] mem_addr,
	output logic [15:0]                 mem_wdata,
	output logic                        rdata_vld,
	output logic                        rdata_cpu,
	output logic [15:0]                 rdata
);

	logic wr_pick;
	logic cpu_pick;
	logic snd_pick;

	// a request whose grant is showing this cycle is already served
	assign wr_pick  = wr_req & ~wr_gnt;
	assign cpu_pick = cpu_req & ~cpu_gnt & ~wr_pick;
	assign snd_pick = snd_req & ~snd_gnt & ~wr_pick & ~cpu_pick;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_gnt    <= 1'b0;
			cpu_gnt   <= 1'b0;
			snd_gnt   <= 1'b0;
			mem_en    <= 1'b0;
			mem_we    <= 1'b0;
			rdata_vld <= 1'b0;
			rdata_cpu <= 1'b0;
		end else begin
			wr_gnt  <= wr_pick;
			cpu_gnt <= cpu_pick;
			snd_gnt <= snd_pick;
			mem_en  <= wr_pick | cpu_pick | snd_pick;
			mem_we  <= wr_pick;

			// the store returns the word one cycle after the command
			rdata_vld <= mem_en & ~mem_we;
			rdata_cpu <= cpu_gnt;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_pick) begin
			mem_addr  <= wr_addr;
			mem_be    <= wr_be;
			mem_wdata <= wr_data;
		end else if (cpu_pick) begin
			mem_addr <= cpu_addr;
		end else if (snd_pick) begin
			mem_addr <= snd_addr;
		end
	end

	assign rdata = mem_rdata;   // both ports see it and the tag picks the owner

endmodule

// ==== rom_store.sv ====
`timescale 1ns/1ps

module rom_store (
	input  logic                        clk_sys,
	input  logic                        en,
	input  logic                        we,
	input  logic [1:0]                  be,
	input  logic [m62_pkg::word_aw-1:0] addr,
	input  m62_pkg::rom_word_t          wdata,
	output m62_pkg::rom_word_t          rdata
);

	m62_pkg::rom_word_t mem [0:(1 << m62_pkg::word_aw)-1];

	always_ff @(posedge clk_sys) begin
		if (en) begin
			if (we) begin
				if (be[1])
					mem[addr].b.hi <= wdata.b.hi;
				if (be[0])
					mem[addr].b.lo <= wdata.b.lo;
			end else begin
				rdata <= mem[addr];
			end
		end
	end

endmodule

// ==== rom_fetch_port.sv ====
`timescale 1ns/1ps

module rom_fetch_port #(
	parameter logic [m62_pkg::byte_aw-1:0] region_base = '0,
	parameter int                          aw          = 16
) (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        req,
	input  logic [aw-1:0]               addr,
	input  logic                        gnt,
	input  logic                        rdata_vld,
	input  logic                        rdata_mine,
	input  m62_pkg::rom_word_t          rdata,
	output logic                        rd_req,
	output logic [m62_pkg::word_aw-1:0] rd_addr,
	output logic [7:0]                  data,
	output logic                        ack
);

	logic [m62_pkg::word_aw:0] byte_addr;   // byte address inside the shared memory
	logic                      wait_data;
	logic                      take;
	logic                      hit;

	assign take = req & ~rd_req & ~wait_data;   // only accepted when idle
	assign hit  = wait_data & rdata_vld & rdata_mine;

	assign rd_addr = byte_addr[m62_pkg::word_aw:1];

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rd_req    <= 1'b0;
			wait_data <= 1'b0;
			ack       <= 1'b0;
		end else begin
			ack <= 1'b0;
			if (take) begin
				rd_req <= 1'b1;
			end else if (gnt) begin
				rd_req    <= 1'b0;
				wait_data <= 1'b1;
			end else if (hit) begin
				wait_data <= 1'b0;
				ack       <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (take)
			byte_addr <= {{(m62_pkg::word_aw + 1 - aw){1'b0}}, addr}
				+ region_base[m62_pkg::word_aw:0];
		if (hit)
			data <= byte_addr[0] ? rdata.b.hi : rdata.b.lo;   // odd byte on high lane
	end

endmodule

// ==== reset_gen.sv ====
`timescale 1ns/1ps

module reset_gen (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic rom_loaded,
	input  logic reset_btn,
	output logic game_reset
);

	logic [$clog2(m62_pkg::reset_hold + 1)-1:0] hold_cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			hold_cnt   <= $bits(hold_cnt)'(m62_pkg::reset_hold);
			game_reset <= 1'b1;
		end else begin
			if (!rom_loaded || reset_btn)
				hold_cnt <= $bits(hold_cnt)'(m62_pkg::reset_hold);   // keep reloading
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			game_reset <= (hold_cnt != '0);
		end
	end

endmodule

// ==== m62_rom_sys.sv ====
`timescale 1ns/1ps

module m62_rom_sys (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        dl_active,
	input  logic                        dl_wr,
	input  logic [m62_pkg::byte_aw-1:0] dl_addr,
	input  logic [7:0]                  dl_data,
	input  logic                        reset_btn,
	input  logic [m62_pkg::cpu_aw-1:0]  cpu_addr,
	input  logic                        cpu_req,
	input  logic [m62_pkg::snd_aw-1:0]  snd_addr,
	input  logic                        snd_req,
	output logic [7:0]                  cpu_data,
	output logic                        cpu_ack,
	output logic [7:0]                  snd_data,
	output logic                        snd_ack,
	output logic                        rom_loaded,
	output logic                        game_reset
);

	logic                        wr_req, wr_gnt;
	logic [m62_pkg::word_aw-1:0] wr_addr;
	logic [15:0]                 wr_data;
	logic [1:0]                  wr_be;

	logic                        cpu_rd_req, cpu_gnt;
	logic [m62_pkg::word_aw-1:0] cpu_rd_addr;
	logic                        snd_rd_req, snd_gnt;
	logic [m62_pkg::word_aw-1:0] snd_rd_addr;

	logic                        mem_en, mem_we;
	logic [1:0]                  mem_be;
	logic [m62_pkg::word_aw-1:0] mem_addr;
	logic [15:0]                 mem_wdata, mem_rdata;
	logic                        rdata_vld, rdata_cpu;
	logic [15:0]                 rdata;

	rom_dl_ctrl u_dl_ctrl (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.dl_active(dl_active), .dl_wr(dl_wr), .dl_addr(dl_addr), .dl_data(dl_data),
		.wr_gnt(wr_gnt), .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
		.wr_be(wr_be), .rom_loaded(rom_loaded)
	);

	rom_arbiter u_arbiter (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_be(wr_be),
		.cpu_req(cpu_rd_req), .cpu_addr(cpu_rd_addr),
		.snd_req(snd_rd_req), .snd_addr(snd_rd_addr),
		.mem_rdata(mem_rdata),
		.wr_gnt(wr_gnt), .cpu_gnt(cpu_gnt), .snd_gnt(snd_gnt),
		.mem_en(mem_en), .mem_we(mem_we), .mem_be(mem_be), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.rdata_vld(rdata_vld), .rdata_cpu(rdata_cpu), .rdata(rdata)
	);

	rom_store u_store (
		.clk_sys(clk_sys), .en(mem_en), .we(mem_we), .be(mem_be),
		.addr(mem_addr), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	rom_fetch_port #(.region_base(m62_pkg::cpu_base), .aw(m62_pkg::cpu_aw)) u_cpu_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .req(cpu_req), .addr(cpu_addr),
		.gnt(cpu_gnt), .rdata_vld(rdata_vld), .rdata_mine(rdata_cpu), .rdata(rdata),
		.rd_req(cpu_rd_req), .rd_addr(cpu_rd_addr), .data(cpu_data), .ack(cpu_ack)
	);

	rom_fetch_port #(.region_base(m62_pkg::snd_base), .aw(m62_pkg::snd_aw)) u_snd_port (
		.clk_sys(clk_sys), .rst_n(rst_n), .req(snd_req), .addr(snd_addr),
		.gnt(snd_gnt), .rdata_vld(rdata_vld), .rdata_mine(~rdata_cpu), .rdata(rdata),
		.rd_req(snd_rd_req), .rd_addr(snd_rd_addr), .data(snd_data), .ack(snd_ack)
	);

	reset_gen u_reset_gen (
		.clk_sys(clk_sys), .rst_n(rst_n), .rom_loaded(rom_loaded),
		.reset_btn(reset_btn), .game_reset(game_reset)
	);

endmodule

// ==== tb_m62_rom_sys.sv ====
`timescale 1ns/1ps

module tb_m62_rom_sys;

	logic        clk_sys;
	logic        rst_n;
	logic        dl_active;
	logic        dl_wr;
	logic [19:0] dl_addr;
	logic [7:0]  dl_data;
	logic        reset_btn;
	logic [16:0] cpu_addr;
	logic        cpu_req;
	logic [15:0] snd_addr;
	logic        snd_req;
	logic [7:0]  cpu_data;
	logic        cpu_ack;
	logic [7:0]  snd_data;
	logic        snd_ack;
	logic        rom_loaded;
	logic        game_reset;

	logic [7:0]  model [int];   // byte address -> last rom byte written
	logic [31:0] c_addr[$], c_exp[$], s_addr[$], s_exp[$];

	m62_rom_sys DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic download_byte(input logic [31:0] a, input logic [31:0] d);
		int gap;
		dl_addr = a[19:0];
		dl_data = d[7:0];
		dl_wr = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		gap = 4 + int'($urandom % 4);   // 4 to 7 cycles between strobes
		repeat (gap - 1) @(negedge clk_sys);
		check_val("game_reset", 32'(game_reset), 1);
	endtask

	task automatic fetch_one(input bit is_cpu, input logic [31:0] a, input logic [31:0] exp);
		int cycles;
		cpu_addr = a[16:0];
		snd_addr = a[15:0];
		cpu_req = is_cpu;
		snd_req = !is_cpu;
		@(negedge clk_sys);
		cpu_req = 1'b0;
		snd_req = 1'b0;
		cycles = 0;
		while (is_cpu ? !cpu_ack : !snd_ack) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > 40) begin
				$display("no ack within 40 cycles for the fetch at address %h", a);
				abort_run();
			end
		end
		if (is_cpu)
			check_val("cpu_data", 32'(cpu_data), exp);
		else
			check_val("snd_data", 32'(snd_data), exp);
		check_val("ack_latency", cycles, 3);   // uncontended path
	endtask

	task automatic fetch_pair(input logic [31:0] ca, input logic [31:0] ce,
		input logic [31:0] sa, input logic [31:0] se);
		int cycles;
		bit cpu_done;
		bit snd_done;
		cpu_addr = ca[16:0];
		snd_addr = sa[15:0];
		cpu_req = 1'b1;
		snd_req = 1'b1;
		@(negedge clk_sys);
		cpu_req = 1'b0;
		snd_req = 1'b0;
		cycles = 0;
		cpu_done = 1'b0;
		snd_done = 1'b0;
		while (!(cpu_done && snd_done)) begin
			@(negedge clk_sys);
			cycles++;
			cpu_done = cpu_done | cpu_ack;
			snd_done = snd_done | snd_ack;
			if (cycles > 40) begin
				$display("simultaneous fetch did not finish within 40 cycles");
				abort_run();
			end
		end
		check_val("cpu_data", 32'(cpu_data), ce);   // data stays latched after ack
		check_val("snd_data", 32'(snd_data), se);
	endtask

	initial begin
		int fd;
		int r;
		int key;
		int cycles;
		logic [7:0] kind;
		logic [31:0] a;
		logic [31:0] d;
		string rest;
		void'($urandom(32'h85e0));
		rst_n = 1'b0;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		reset_btn = 1'b0;
		cpu_addr = '0;
		cpu_req = 1'b0;
		snd_addr = '0;
		snd_req = 1'b0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		@(negedge clk_sys);
		check_val("cpu_ack", 32'(cpu_ack), 0);
		check_val("snd_ack", 32'(snd_ack), 0);
		check_val("rom_loaded", 32'(rom_loaded), 0);
		check_val("game_reset", 32'(game_reset), 1);

		fd = $fopen("rom_input.txt", "r");
		if (fd == 0) begin
			$display("could not open rom_input.txt");
			abort_run();
		end
		dl_active = 1'b1;
		while (!$feof(fd)) begin
			r = $fscanf(fd, " %c", kind);
			if (r != 1)
				break;
			if (kind == "#") begin
				r = $fgets(rest, fd);
				continue;
			end
			r = $fscanf(fd, "%h %h", a, d);
			if (r != 2) begin
				$display("rom_input.txt has a line with missing fields");
				abort_run();
			end
			case (kind)
				"W": begin
					download_byte(a, d);
					if (a[19:0] < m62_pkg::rom_end)
						model[int'(a)] = d[7:0];   // gfx region is dropped
				end
				"C": begin
					c_addr.push_back(a);
					c_exp.push_back(d);
				end
				"S": begin
					s_addr.push_back(a);
					s_exp.push_back(d);
				end
				default: begin
					$display("rom_input.txt has an unknown line kind");
					abort_run();
				end
			endcase
		end
		$fclose(fd);

		// button held across the end of the download
		reset_btn = 1'b1;
		dl_active = 1'b0;
		cycles = 0;
		while (!rom_loaded) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > 10) begin
				$display("rom_loaded never rose after the download ended");
				abort_run();
			end
		end
		check_val("rom_loaded_delay", cycles, 1);
		repeat (2 * m62_pkg::reset_hold) begin
			@(negedge clk_sys);
			check_val("game_reset", 32'(game_reset), 1);
		end
		reset_btn = 1'b0;
		cycles = 0;
		while (game_reset) begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > m62_pkg::reset_hold + 8) begin
				$display("game_reset still high long after loading");
				abort_run();
			end
		end
		check_val("game_reset_hold_done", 32'(cycles >= m62_pkg::reset_hold), 1);

		// the data file must agree with the download model
		foreach (c_addr[i]) begin
			key = int'(m62_pkg::cpu_base) + int'(c_addr[i]);
			if (!model.exists(key)) begin
				$display("cpu read at %h has no downloaded byte", c_addr[i]);
				abort_run();
			end
			check_val("cpu_expected", c_exp[i], 32'(model[key]));
			fetch_one(1'b1, c_addr[i], c_exp[i]);
		end
		foreach (s_addr[i]) begin
			key = int'(m62_pkg::snd_base) + int'(s_addr[i]);
			if (!model.exists(key)) begin
				$display("sound read at %h has no downloaded byte", s_addr[i]);
				abort_run();
			end
			check_val("snd_expected", s_exp[i], 32'(model[key]));
			fetch_one(1'b0, s_addr[i], s_exp[i]);
		end
		for (int i = 0; i < c_addr.size() && i < s_addr.size(); i++)
			fetch_pair(c_addr[i], c_exp[i], s_addr[i], s_exp[i]);

		$display("Regression passed");
		$finish;
	end

endmodule

// ==== rom_input.txt ====
# W byte_addr data : download one byte
# C cpu_addr expected_byte / S snd_addr expected_byte : fetch and compare
W 00000 3e
W 00001 c1
W 00002 5a
W 00003 a7
W 01234 19
W 1ffff 0d
W 20000 f3
W 20001 31
W 20004 6b
W 20005 c9
W 30004 ff
W 00002 96
C 00000 3e
C 00001 c1
C 00002 96
C 00003 a7
C 01234 19
C 1ffff 0d
S 0000 f3
S 0001 31
S 0004 6b
S 0005 c9

// ==== sources.f ====
m62_pkg.sv
rom_dl_ctrl.sv
rom_arbiter.sv
rom_store.sv
rom_fetch_port.sv
reset_gen.sv
m62_rom_sys.sv
tb_m62_rom_sys.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module tb_m62_rom_sys -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "Regression passed" &&
echo "run.sh: PASS" || { echo "run.sh: FAIL"; exit 1; }
